// File: mipsCore.f
+incdir+hw
hw/mipsPkg.sv
hw/control.sv
hw/aluUnit.sv
hw/regFile.sv
hw/pcUnit.sv
hw/mipsCore.sv
verification/mipsCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -Mdir obj_dir \
	--top-module mipsCore_tb -f mipsCore.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VmipsCore_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/mipsCore_tb.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mipsCore_tb
	import mipsPkg::*;
();

	localparam int numInstr    = 2000;
	localparam int resetCycles = 2;
	localparam int resetLimit  = 10;
	localparam int cycleLimit  = numInstr + 100;

	localparam funct_t rFuncts [9] = '{functAddu, functSubu, functAnd, functOr, functXor,
		functSlt, functSltu, functSll, functSrl};
	localparam opcode_t iOps [7] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
	localparam logic [5:0] badOps [8] = '{opRegimm, opJal, opBlez, opBgtz, opLb, opSh,
		6'd8, 6'd63};
	localparam logic [5:0] badFuncts [8] = '{functSra, functSllv, functSrlv, functSrav,
		functJalr, functMthi, functMult, functDivu};

	logic        clk;
	logic        rstN;
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic        memRead;
	logic        memWrite;
	logic [31:0] memRdata;

	integer      seed;
	logic [31:0] mReg [32];
	logic [31:0] mMem [64];
	logic [31:0] mPc;
	logic        expRead;
	logic        expWrite;
	logic        expWrEn;
	logic [4:0]  expWrIdx;
	logic [31:0] expAddr;
	logic [31:0] expWdata;
	logic [31:0] expWrVal;
	logic [31:0] expNextPc;

	mipsCore dut_i (
		.clk      (clk),
		.rstN     (rstN),
		.pc       (pc),
		.instr    (instr),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.memRead  (memRead),
		.memWrite (memWrite),
		.memRdata (memRdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic stopOnTimeout(input string what);
		$display("timeout: %s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic makeInstr(output logic [31:0] w);
		int          cls;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [31:0] target;
		logic [31:0] off;
		cls = $unsigned($random(seed)) % 20;
		rs = 5'($unsigned($random(seed)) % 8);
		rt = 5'($unsigned($random(seed)) % 8);
		rd = 5'($unsigned($random(seed)) % 8);
		if ($random(seed) & 1)
			imm = 16'($random(seed));
		else
			imm = 16'($unsigned($random(seed)) % 256); // small values keep bases in reach.
		w = 32'($random(seed));
		if (cls < 5) begin
			w = {opSpecial, rs, rt, rd, w[10:6], rFuncts[$unsigned($random(seed)) % 9]};
		end else if (cls < 9) begin
			w = {iOps[$unsigned($random(seed)) % 7], rs, rt, imm};
		end else if (cls < 14) begin
			target = {24'h0, 6'($unsigned($random(seed)) % 64), 2'b00}; // word in the window.
			off = target - mReg[rs];
			if (!(&off[31:15] || ~|off[31:15])) begin
				rs = 5'd0; // offset too wide, address straight from r0.
				off = target;
			end
			w = {(cls < 11) ? opLw : opSw, rs, rt, off[15:0]};
		end else if (cls < 16) begin
			if ($random(seed) & 1)
				rt = rs; // equal operands.
			w = {(cls == 14) ? opBeq : opBne, rs, rt, imm};
		end else if (cls == 16) begin
			w = {opJ, w[25:0]};
		end else if (cls == 17) begin
			if (mReg[rs][1:0] != 2'b00)
				rs = 5'd0;
			w = {opSpecial, rs, 15'd0, functJr};
		end else if ($random(seed) & 1) begin
			w[31:26] = 6'd0;
			w[5:0] = badFuncts[$unsigned($random(seed)) % 8];
		end else begin
			w[31:26] = badOps[$unsigned($random(seed)) % 8];
		end
	endtask

	task automatic predictEffects(input logic [31:0] w);
		opcode_t     op;
		funct_t      fn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] pc4;
		op = opcode_t'(w[31:26]);
		fn = funct_t'(w[5:0]);
		a = mReg[w[25:21]];
		b = mReg[w[20:16]];
		se = {{16{w[15]}}, w[15:0]};
		ze = {16'h0000, w[15:0]};
		pc4 = mPc + 32'd4;
		expRead = 1'b0;
		expWrite = 1'b0;
		expWrEn = 1'b0;
		expWrIdx = w[20:16];
		expAddr = 32'd0;
		expWdata = 32'd0;
		expWrVal = 32'd0;
		expNextPc = pc4;
		case (op)
			opSpecial: begin
				expWrEn = 1'b1;
				expWrIdx = w[15:11];
				case (fn)
					functAddu: expWrVal = a + b;
					functSubu: expWrVal = a - b;
					functAnd:  expWrVal = a & b;
					functOr:   expWrVal = a | b;
					functXor:  expWrVal = a ^ b;
					functSlt:  expWrVal = 32'($signed(a) < $signed(b));
					functSltu: expWrVal = 32'(a < b);
					functSll:  expWrVal = b << w[10:6];
					functSrl:  expWrVal = b >> w[10:6];
					functJr: begin
						expWrEn = 1'b0;
						expNextPc = a;
					end
					default:   expWrEn = 1'b0;
				endcase
			end
			opJ:     expNextPc = {pc4[31:28], w[25:0], 2'b00};
			opBeq:
				if (a == b)
					expNextPc = pc4 + (se << 2);
			opBne:
				if (a != b)
					expNextPc = pc4 + (se << 2);
			opAddiu: expWrVal = a + se;
			opSlti:  expWrVal = 32'($signed(a) < $signed(se));
			opSltiu: expWrVal = 32'(a < se);
			opAndi:  expWrVal = a & ze;
			opOri:   expWrVal = a | ze;
			opXori:  expWrVal = a ^ ze;
			opLui:   expWrVal = {w[15:0], 16'h0000};
			opLw: begin
				expRead = 1'b1;
				expAddr = a + se;
				expWrVal = mMem[expAddr[7:2]];
			end
			opSw: begin
				expWrite = 1'b1;
				expAddr = a + se;
				expWdata = b;
			end
			default: ; // anything else is a no-op.
		endcase
		if (op inside {opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLw})
			expWrEn = 1'b1;
	endtask

	task automatic applyEffects();
		if (expWrite)
			mMem[expAddr[7:2]] = expWdata;
		if (expWrEn && expWrIdx != 5'd0)
			mReg[expWrIdx] = expWrVal; // r0 stays zero.
		mPc = expNextPc;
	endtask

	initial begin
		int          cyc;
		int          retired;
		logic [31:0] word;
		seed = 32'he616_d6be;
		rstN = 1'b0;
		instr = {opSw, 26'd0}; // a store, then a load, so ungated strobes would show in reset.
		memRdata = 32'd0;
		mPc = `MIPS_RESET_PC;
		for (int i = 0; i < 32; i++)
			mReg[i] = 32'd0;
		for (int i = 0; i < 64; i++)
			mMem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;

		cyc = 0;
		while (!rstN) begin
			@(posedge clk);
			#2;
			checkEq(pc, `MIPS_RESET_PC, "pc during reset");
			checkEq(32'(memRead), 32'd0, "memRead during reset");
			checkEq(32'(memWrite), 32'd0, "memWrite during reset");
			instr = {opLw, 26'd0};
			cyc++;
			if (cyc > resetLimit)
				stopOnTimeout("reset was not released in time");
			if (cyc >= resetCycles)
				rstN = 1'b1;
		end

		retired = 0;
		cyc = 0;
		while (retired < numInstr) begin
			makeInstr(word);
			predictEffects(word);
			instr = word;
			memRdata = expRead ? mMem[expAddr[7:2]] : 32'($random(seed));
			#10;
			checkEq(pc, mPc, "pc");
			checkEq(32'(memRead), 32'(expRead), "memRead");
			checkEq(32'(memWrite), 32'(expWrite), "memWrite");
			if (expRead || expWrite)
				checkEq(memAddr, expAddr, "memAddr");
			if (expWrite)
				checkEq(memWdata, expWdata, "memWdata");
			applyEffects();
			retired++;
			cyc++;
			if (cyc > cycleLimit)
				stopOnTimeout("instruction loop did not finish in time");
			@(posedge clk);
			#2;
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: hw/mipsCore.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mipsCore
	import mipsPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	output logic [`MIPS_XLEN-1:0] pc,
	input  logic [31:0]           instr,
	output logic [`MIPS_XLEN-1:0] memAddr,
	output logic [`MIPS_XLEN-1:0] memWdata,
	output logic                  memRead,
	output logic                  memWrite,
	input  logic [`MIPS_XLEN-1:0] memRdata
);

	ctrlSig_t              ctrl;
	logic [4:0]            wrIdx;
	logic [`MIPS_XLEN-1:0] rsVal;
	logic [`MIPS_XLEN-1:0] rtVal;
	logic [`MIPS_XLEN-1:0] aluResult;
	logic [`MIPS_XLEN-1:0] wbData;

	control ctrl_i (
		.clk         (clk),
		.rstN        (rstN),
		.insop       (opcode_t'(instr[31:26])),
		.branchfield (instr[20:16]),
		.func        (funct_t'(instr[5:0])),
		.ctrl        (ctrl)
	);

	assign wrIdx  = ctrl.regDst ? instr[15:11] : instr[20:16]; // rd for R-type, else rt.
	assign wbData = ctrl.memToReg ? memRdata : aluResult;

	regFile regFile_i (
		.clk    (clk),
		.rstN   (rstN),
		.rsIdx  (instr[25:21]),
		.rtIdx  (instr[20:16]),
		.wrIdx  (wrIdx),
		.wrEn   (ctrl.regWrite),
		.wrData (wbData),
		.rsVal  (rsVal),
		.rtVal  (rtVal)
	);

	aluUnit alu_i (
		.instr  (instr),
		.rsVal  (rsVal),
		.rtVal  (rtVal),
		.aluSrc (ctrl.aluSrc),
		.aluOp  (ctrl.aluOp),
		.result (aluResult)
	);

	pcUnit pc_i (
		.clk    (clk),
		.rstN   (rstN),
		.instr  (instr),
		.rsVal  (rsVal),
		.rtVal  (rtVal),
		.branch (ctrl.branch),
		.jump   (ctrl.jump),
		.pc     (pc)
	);

	assign memAddr  = aluResult;
	assign memWdata = rtVal;

	// strobes stay quiet while the core is held in reset.
	assign memRead  = ctrl.memRead & rstN;
	assign memWrite = ctrl.memWrite & rstN;

endmodule

// File: hw/pcUnit.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module pcUnit
	import mipsPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [31:0]           instr,
	input  logic [`MIPS_XLEN-1:0] rsVal,
	input  logic [`MIPS_XLEN-1:0] rtVal,
	input  logic                  branch,
	input  logic                  jump,
	output logic [`MIPS_XLEN-1:0] pc
);

	opcode_t               op;
	logic                  taken;
	logic [`MIPS_XLEN-1:0] pcPlus4;
	logic [`MIPS_XLEN-1:0] brTarget;
	logic [`MIPS_XLEN-1:0] jTarget;
	logic [`MIPS_XLEN-1:0] pcNext;

	assign op       = opcode_t'(instr[31:26]);
	assign pcPlus4  = pc + `MIPS_XLEN'd4;
	assign brTarget = pcPlus4 + {{(`MIPS_XLEN-18){instr[15]}}, instr[15:0], 2'b00};
	assign jTarget  = {pcPlus4[`MIPS_XLEN-1:28], instr[25:0], 2'b00}; // stays in the 256MB region.

	always_comb begin
		case (op)
			opBeq:   taken = (rsVal == rtVal);
			opBne:   taken = (rsVal != rtVal);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (jump)
			pcNext = (op == opSpecial) ? rsVal : jTarget; // jr or j.
		else if (branch && taken)
			pcNext = brTarget;
		else
			pcNext = pcPlus4;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `MIPS_RESET_PC;
		else
			pc <= pcNext;
	end

	pcAligned: assert property (
		@(posedge clk) disable iff (!rstN)
		pc[1:0] == 2'b00
	) else $error("pcUnit: pc not word aligned.");

endmodule

// File: hw/regFile.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module regFile (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [4:0]            rsIdx,
	input  logic [4:0]            rtIdx,
	input  logic [4:0]            wrIdx,
	input  logic                  wrEn,
	input  logic [`MIPS_XLEN-1:0] wrData,
	output logic [`MIPS_XLEN-1:0] rsVal,
	output logic [`MIPS_XLEN-1:0] rtVal
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `MIPS_NREGS; i++)
				regs[i] <= '0;
		end else if (wrEn && wrIdx != 5'd0) begin
			regs[wrIdx] <= wrData; // r0 writes are dropped.
		end
	end

	assign rsVal = regs[rsIdx];
	assign rtVal = regs[rtIdx];

	// r0 reads as zero on both ports in every cycle.
	zeroReg: assert property (
		@(posedge clk) disable iff (!rstN)
		((rsIdx == 5'd0) |-> (rsVal == '0)) and ((rtIdx == 5'd0) |-> (rtVal == '0))
	) else $error("regFile: r0 read returned nonzero.");

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module aluUnit
	import mipsPkg::*;
(
	input  logic [31:0]           instr,
	input  logic [`MIPS_XLEN-1:0] rsVal,
	input  logic [`MIPS_XLEN-1:0] rtVal,
	input  logic                  aluSrc,
	input  aluOp_t                aluOp,
	output logic [`MIPS_XLEN-1:0] result
);

	opcode_t               op;
	funct_t                fn;
	aluFn_t                fnSel;
	logic [4:0]            shamt;
	logic [`MIPS_XLEN-1:0] immSext;
	logic [`MIPS_XLEN-1:0] immZext;
	logic [`MIPS_XLEN-1:0] opB;

	assign op      = opcode_t'(instr[31:26]);
	assign fn      = funct_t'(instr[5:0]);
	assign shamt   = instr[10:6];
	assign immSext = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};
	assign immZext = {{(`MIPS_XLEN-16){1'b0}}, instr[15:0]};

	always_comb begin
		fnSel = aluAdd;
		case (aluOp)
			aluOpAdd: fnSel = aluAdd; // address generation.
			aluOpSub: fnSel = aluSub;
			aluOpFunc: begin
				case (fn)
					functSubu: fnSel = aluSub;
					functAnd:  fnSel = aluAnd;
					functOr:   fnSel = aluOr;
					functXor:  fnSel = aluXor;
					functSlt:  fnSel = aluSlt;
					functSltu: fnSel = aluSltu;
					functSll:  fnSel = aluSll;
					functSrl:  fnSel = aluSrl;
					default:   fnSel = aluAdd;
				endcase
			end
			aluOpImm: begin
				case (op)
					opSlti:  fnSel = aluSlt;
					opSltiu: fnSel = aluSltu; // compares against the sign-extended immediate.
					opAndi:  fnSel = aluAnd;
					opOri:   fnSel = aluOr;
					opXori:  fnSel = aluXor;
					opLui:   fnSel = aluLui;
					default: fnSel = aluAdd;
				endcase
			end
			default: fnSel = aluAdd;
		endcase
	end

	always_comb begin
		if (!aluSrc)
			opB = rtVal;
		else if (op inside {opAndi, opOri, opXori})
			opB = immZext; // logical immediates are unsigned.
		else
			opB = immSext;
	end

	always_comb begin
		case (fnSel)
			aluAdd:  result = rsVal + opB;
			aluSub:  result = rsVal - opB;
			aluAnd:  result = rsVal & opB;
			aluOr:   result = rsVal | opB;
			aluXor:  result = rsVal ^ opB;
			aluSlt:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(rsVal) < $signed(opB)};
			aluSltu: result = {{(`MIPS_XLEN-1){1'b0}}, rsVal < opB};
			aluSll:  result = opB << shamt; // shifts operate on rt.
			aluSrl:  result = opB >> shamt;
			aluLui:  result = {opB[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// File: hw/control.sv
`timescale 1ns/10ps

module control
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  opcode_t  insop,
	input  logic [4:0] branchfield,
	input  funct_t   func,
	output ctrlSig_t ctrl
);

	// field order: regDst jump branch memRead memWrite memToReg regWrite aluSrc aluOp.
	localparam ctrlSig_t ctrlNone  = ctrlSig_t'(10'b0000000000);
	localparam ctrlSig_t ctrlRType = ctrlSig_t'(10'b1000001010);
	localparam ctrlSig_t ctrlJump  = ctrlSig_t'(10'b0100000000);
	localparam ctrlSig_t ctrlImm   = ctrlSig_t'(10'b0000001111);
	localparam ctrlSig_t ctrlLoad  = ctrlSig_t'(10'b0001011100);
	localparam ctrlSig_t ctrlStore = ctrlSig_t'(10'b0000100100);
	localparam ctrlSig_t ctrlBr    = ctrlSig_t'(10'b0010000001);

	always_comb begin
		ctrl = ctrlNone; // anything not listed retires as a no-op.
		case (insop)
			opSpecial: begin
				case (func)
					functAddu,
					functSubu,
					functAnd,
					functOr,
					functXor,
					functSlt,
					functSltu,
					functSll,
					functSrl: ctrl = ctrlRType;
					functJr:  ctrl = ctrlJump; // target comes from rs.
					default:  ctrl = ctrlNone;
				endcase
			end
			opRegimm: ctrl = ctrlNone; // bltz, bgez and the linking forms are not implemented.
			opJ:     ctrl = ctrlJump;
			opBeq,
			opBne:   ctrl = ctrlBr;
			opAddiu,
			opSlti,
			opSltiu,
			opAndi,
			opOri,
			opXori,
			opLui:   ctrl = ctrlImm;
			opLw:    ctrl = ctrlLoad;
			opSw:    ctrl = ctrlStore;
			default: ctrl = ctrlNone;
		endcase
	end

	// a load and a store in the same cycle would confuse the memory port.
	memExclusive: assert property (
		@(posedge clk) disable iff (!rstN)
		!(ctrl.memRead && ctrl.memWrite)
	) else $error("control: memRead and memWrite both set.");

endmodule

// File: hw/mipsPkg.sv
package mipsPkg;

	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opRegimm  = 6'd1,
		opJ       = 6'd2,
		opJal     = 6'd3,
		opBeq     = 6'd4,
		opBne     = 6'd5,
		opBlez    = 6'd6,
		opBgtz    = 6'd7,
		opAddiu   = 6'd9,
		opSlti    = 6'd10,
		opSltiu   = 6'd11,
		opAndi    = 6'd12,
		opOri     = 6'd13,
		opXori    = 6'd14,
		opLui     = 6'd15,
		opLb      = 6'd32,
		opLh      = 6'd33,
		opLwl     = 6'd34,
		opLw      = 6'd35,
		opLbu     = 6'd36,
		opLhu     = 6'd37,
		opLwr     = 6'd38,
		opSb      = 6'd40,
		opSh      = 6'd41,
		opSw      = 6'd43
	} opcode_t;

	typedef enum logic [5:0] {
		functSll   = 6'd0,
		functSrl   = 6'd2,
		functSra   = 6'd3,
		functSllv  = 6'd4,
		functSrlv  = 6'd6,
		functSrav  = 6'd7,
		functJr    = 6'd8,
		functJalr  = 6'd9,
		functMthi  = 6'd17,
		functMtlo  = 6'd19,
		functMult  = 6'd24,
		functMultu = 6'd25,
		functDiv   = 6'd26,
		functDivu  = 6'd27,
		functAddu  = 6'd33,
		functSubu  = 6'd35,
		functAnd   = 6'd36,
		functOr    = 6'd37,
		functXor   = 6'd38,
		functSlt   = 6'd42,
		functSltu  = 6'd43
	} funct_t;

	// operation class handed from the main decoder to the ALU.
	typedef enum logic [1:0] {
		aluOpAdd  = 2'b00,
		aluOpSub  = 2'b01,
		aluOpFunc = 2'b10,
		aluOpImm  = 2'b11
	} aluOp_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluLui
	} aluFn_t;

	// msb first, same bit order as the original decoder word.
	typedef struct packed {
		logic   regDst;
		logic   jump;
		logic   branch;
		logic   memRead;
		logic   memWrite;
		logic   memToReg;
		logic   regWrite;
		logic   aluSrc;
		aluOp_t aluOp;
	} ctrlSig_t;

endpackage

// File: hw/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// data path and address width.
`define MIPS_XLEN 32

// architectural register count.
`define MIPS_NREGS 32

// first fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

`endif
